/* ooo_core.f */
+incdir+dv
hw/ooo_pkg.sv
hw/cdb_if.sv
hw/arch_regfile.sv
hw/rename_table.sv
hw/reorder_buffer.sv
hw/exec_lane.sv
hw/dispatch_unit.sv
hw/ooo_core.sv
dv/ooo_core_tb.sv

/* Bender.yml */
package:
  name: ooo_core

sources:
  - target: rtl
    files:
      - hw/ooo_pkg.sv
      - hw/cdb_if.sv
      - hw/arch_regfile.sv
      - hw/rename_table.sv
      - hw/reorder_buffer.sv
      - hw/exec_lane.sv
      - hw/dispatch_unit.sv
      - hw/ooo_core.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/ooo_core_tb.sv

/* dv/ooo_core_ref.svh */
`ifndef OOO_CORE_REF_SVH
`define OOO_CORE_REF_SVH

// architectural registers as a sequential machine would leave them
logic [ooo_pkg::xlen-1:0] model_regs [ooo_pkg::num_regs];

// destination and result of every accepted instruction, oldest first
logic [ooo_pkg::reg_idx_w-1:0] exp_rd_q [$];
logic [ooo_pkg::xlen-1:0] exp_val_q [$];

// oldest expected commit mirrored into plain variables for the assertions
logic head_valid;
logic [ooo_pkg::reg_idx_w-1:0] head_rd;
logic [ooo_pkg::xlen-1:0] head_val;

function automatic void refresh_head();
    head_valid = (exp_rd_q.size() > 0);
    head_rd = head_valid ? exp_rd_q[0] : '0;
    head_val = head_valid ? exp_val_q[0] : '0;
endfunction

function automatic void model_reset();
    for (int i = 0; i < ooo_pkg::num_regs; i++) begin
        model_regs[i] = '0;
    end
    exp_rd_q.delete();
    exp_val_q.delete();
    refresh_head();
endfunction

// run one instruction in program order and queue its commit
function automatic void model_execute(
    input ooo_pkg::alu_op_e op,
    input logic [ooo_pkg::reg_idx_w-1:0] rd,
    input logic [ooo_pkg::reg_idx_w-1:0] rs1,
    input logic [ooo_pkg::reg_idx_w-1:0] rs2,
    input logic [15:0] imm
);
    logic [ooo_pkg::xlen-1:0] x;
    logic [ooo_pkg::xlen-1:0] y;
    logic [ooo_pkg::xlen-1:0] res;
    x = model_regs[rs1];
    y = model_regs[rs2];
    case (op)
        ooo_pkg::op_li:  res = {16'h0000, imm};
        ooo_pkg::op_add: res = x + y;
        ooo_pkg::op_sub: res = x - y;
        ooo_pkg::op_and: res = x & y;
        ooo_pkg::op_xor: res = x ^ y;
        default:         res = x * y;
    endcase
    model_regs[rd] = res;
    exp_rd_q.push_back(rd);
    exp_val_q.push_back(res);
    refresh_head();
endfunction

function automatic void pop_expected();
    void'(exp_rd_q.pop_front());
    void'(exp_val_q.pop_front());
    refresh_head();
endfunction

`endif

/* dv/ooo_core_tb.sv */
`default_nettype none

module ooo_core_tb;

    localparam int n_li = ooo_pkg::num_regs;
    localparam int n_indep = 40;
    localparam int n_chain = 30;
    localparam int n_ooo_groups = 4;
    localparam int n_mul_run = 24;
    localparam int n_gap = 30;
    localparam int total_insts = n_li + n_indep + n_chain + n_ooo_groups * 5 + n_mul_run + n_gap;
    localparam int watchdog_time = (total_insts * (ooo_pkg::mul_latency + 10) + 40) * 8;

    logic clk;
    logic rst;
    logic inst_req;
    logic inst_ack;
    ooo_pkg::alu_op_e inst_op;
    logic [ooo_pkg::reg_idx_w-1:0] inst_rd;
    logic [ooo_pkg::reg_idx_w-1:0] inst_rs1;
    logic [ooo_pkg::reg_idx_w-1:0] inst_rs2;
    logic [15:0] inst_imm;
    logic commit_valid;
    logic [ooo_pkg::reg_idx_w-1:0] commit_rd;
    logic [ooo_pkg::xlen-1:0] commit_value;

    string test_name;
    int accept_count;
    int commit_count;
    logic idle_phase;
    logic saw_ooo;
    logic saw_stall;

    `include "ooo_core_ref.svh"

    ooo_core i_dut (
        .clk, .rst, .inst_req, .inst_ack, .inst_op, .inst_rd, .inst_rs1, .inst_rs2,
        .inst_imm, .commit_valid, .commit_rd, .commit_value
    );

    always #4 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    function automatic logic [ooo_pkg::reg_idx_w-1:0] rand_reg();
        return ooo_pkg::reg_idx_w'($urandom_range(0, ooo_pkg::num_regs - 1));
    endfunction

    function automatic ooo_pkg::alu_op_e rand_alu_op();
        return ooo_pkg::alu_op_e'($urandom_range(1, 4));
    endfunction

    // full four-phase exchange with the model updated on ack
    task automatic send_inst(
        input ooo_pkg::alu_op_e op,
        input logic [ooo_pkg::reg_idx_w-1:0] rd,
        input logic [ooo_pkg::reg_idx_w-1:0] rs1,
        input logic [ooo_pkg::reg_idx_w-1:0] rs2,
        input logic [15:0] imm
    );
        inst_op = op;
        inst_rd = rd;
        inst_rs1 = rs1;
        inst_rs2 = rs2;
        inst_imm = imm;
        inst_req = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!inst_ack);
        accept_count++;
        model_execute(op, rd, rs1, rs2, imm);
        inst_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (inst_ack);
    endtask

    // commit port side of the model
    always @(posedge clk) begin
        if (!rst && commit_valid) begin
            commit_count++;
            if (head_valid) begin
                pop_expected();
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && i_dut.cdb.valid[0] && i_dut.mul_busy) begin
            saw_ooo = 1'b1;
        end
        if (!rst && i_dut.i_dispatch.state == ooo_pkg::st_wait_operands) begin
            saw_stall = 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) commit_valid |-> head_valid)
        else report_failure("commit seen with no accepted instruction outstanding");

    assert property (@(posedge clk) disable iff (rst)
        commit_valid && head_valid |-> commit_rd == head_rd && commit_value == head_val)
        else report_failure($sformatf(
            "Fail %s: expected rd %0d value 0x%08h, actual rd %0d value 0x%08h",
            test_name, $sampled(head_rd), $sampled(head_val),
            $sampled(commit_rd), $sampled(commit_value)));

    assert property (@(posedge clk) disable iff (rst) idle_phase |-> !inst_ack && !commit_valid)
        else report_failure("inst_ack or commit_valid went high while idle");

    // four-phase ordering on the dispatch port
    assert property (@(posedge clk) disable iff (rst) $rose(inst_ack) |-> $past(inst_req))
        else report_failure("inst_ack rose without inst_req high");
    assert property (@(posedge clk) disable iff (rst) $fell(inst_ack) |-> !$past(inst_req))
        else report_failure("inst_ack fell before inst_req was seen low");

    initial begin
        #watchdog_time;
        report_failure("watchdog expired, the core stopped accepting or committing");
    end

    initial begin
        logic [ooo_pkg::reg_idx_w-1:0] last_rd;
        logic [ooo_pkg::reg_idx_w-1:0] src2;
        logic [ooo_pkg::reg_idx_w-1:0] mul_rd;
        ooo_pkg::alu_op_e op;
        void'($urandom(775));
        clk = 1'b0;
        rst = 1'b1;
        inst_req = 1'b0;
        inst_op = ooo_pkg::op_li;
        inst_rd = '0;
        inst_rs1 = '0;
        inst_rs2 = '0;
        inst_imm = '0;
        accept_count = 0;
        commit_count = 0;
        idle_phase = 1'b0;
        saw_ooo = 1'b0;
        saw_stall = 1'b0;
        test_name = "reset_idle";
        model_reset();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        idle_phase = 1'b1;
        wait_cycles(10);
        idle_phase = 1'b0;

        test_name = "load_imm";
        for (int i = 0; i < n_li; i++) begin
            send_inst(ooo_pkg::op_li, ooo_pkg::reg_idx_w'(i), '0, '0, 16'($urandom()));
        end

        test_name = "independent_alu";
        for (int i = 0; i < n_indep; i++) begin
            send_inst(rand_alu_op(), rand_reg(), rand_reg(), rand_reg(), 16'h0);
        end

        // first source always reads the previous destination and sometimes both do
        test_name = "dependency_chain";
        last_rd = rand_reg();
        for (int i = 0; i < n_chain; i++) begin
            src2 = (i % 3 == 0) ? last_rd : rand_reg();
            op = (i % 5 == 4) ? ooo_pkg::op_mul : rand_alu_op();
            mul_rd = rand_reg();
            send_inst(op, mul_rd, last_rd, src2, 16'h0);
            last_rd = mul_rd;
        end

        test_name = "out_of_order";
        saw_ooo = 1'b0;
        for (int g = 0; g < n_ooo_groups; g++) begin
            mul_rd = rand_reg();
            send_inst(ooo_pkg::op_mul, mul_rd, rand_reg(), rand_reg(), 16'h0);
            // younger ops stay clear of the mul destination
            for (int k = 0; k < 4; k++) begin
                send_inst(rand_alu_op(), mul_rd + 5'(1 + k), mul_rd + 5'(8 + k),
                          mul_rd + 5'(16 + k), 16'h0);
            end
        end
        assert (saw_ooo)
            else report_failure("no ALU result overtook an older mul");

        test_name = "mul_back_pressure";
        saw_stall = 1'b0;
        last_rd = rand_reg();
        for (int i = 0; i < n_mul_run; i++) begin
            mul_rd = rand_reg();
            send_inst(ooo_pkg::op_mul, mul_rd, last_rd, rand_reg(), 16'h0);
            last_rd = mul_rd;
        end
        assert (saw_stall)
            else report_failure("dispatch never stalled on the dependent mul run");

        test_name = "handshake_gaps";
        for (int i = 0; i < n_gap; i++) begin
            op = ooo_pkg::alu_op_e'($urandom_range(0, 5));
            send_inst(op, rand_reg(), rand_reg(), rand_reg(), 16'($urandom()));
            wait_cycles($urandom_range(0, 3));
        end

        test_name = "drain";
        while (head_valid) begin
            @(posedge clk);
            #1;
        end
        // nothing may retire once every expected commit is in
        idle_phase = 1'b1;
        wait_cycles(4);
        idle_phase = 1'b0;
        if (commit_count == accept_count) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            report_failure($sformatf("Fail %s: expected commits %0d, actual %0d",
                test_name, accept_count, commit_count));
        end
    end

endmodule

`default_nettype wire

/* hw/ooo_core.sv */
`default_nettype none

module ooo_core (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          inst_req,
    output logic                          inst_ack,
    input  ooo_pkg::alu_op_e              inst_op,
    input  logic [ooo_pkg::reg_idx_w-1:0] inst_rd,
    input  logic [ooo_pkg::reg_idx_w-1:0] inst_rs1,
    input  logic [ooo_pkg::reg_idx_w-1:0] inst_rs2,
    input  logic [15:0]                   inst_imm,
    output logic                          commit_valid,
    output logic [ooo_pkg::reg_idx_w-1:0] commit_rd,
    output logic [ooo_pkg::xlen-1:0]      commit_value
);

    logic [ooo_pkg::reg_idx_w-1:0] src_a, src_b, rename_rd, rd_idx_a, rd_idx_b, push_rd;
    logic [ooo_pkg::rob_idx_w-1:0] tag_a, tag_b, rename_tag, alloc_tag;
    logic [ooo_pkg::rob_idx_w-1:0] look_tag_a, look_tag_b, retire_tag, issue_tag;
    logic [ooo_pkg::xlen-1:0] rd_data_a, rd_data_b, look_value_a, look_value_b;
    logic [ooo_pkg::xlen-1:0] issue_a, issue_b;
    logic busy_a, busy_b, rename, push, full, look_ready_a, look_ready_b;
    logic alu_issue, mul_issue, alu_busy, mul_busy;
    ooo_pkg::alu_op_e issue_op;

    cdb_if cdb ();

    dispatch_unit i_dispatch (
        .clk, .rst, .inst_req, .inst_ack, .inst_op, .inst_rd, .inst_rs1, .inst_rs2,
        .inst_imm, .src_a, .src_b, .busy_a, .busy_b, .tag_a, .tag_b,
        .rename, .rename_rd, .rename_tag, .rd_idx_a, .rd_idx_b, .rd_data_a, .rd_data_b,
        .push, .push_rd, .alloc_tag, .full, .look_tag_a, .look_tag_b,
        .look_ready_a, .look_ready_b, .look_value_a, .look_value_b,
        .alu_issue, .mul_issue, .issue_op, .issue_a, .issue_b, .issue_tag,
        .alu_busy, .mul_busy
    );

    rename_table i_rename (
        .clk, .rst, .src_a, .src_b, .busy_a, .busy_b, .tag_a, .tag_b,
        .rename, .rename_rd, .rename_tag,
        .retire_valid(commit_valid), .retire_rd(commit_rd), .retire_tag
    );

    arch_regfile i_regfile (
        .clk, .rst, .rd_idx_a, .rd_idx_b, .rd_data_a, .rd_data_b,
        .wr_en(commit_valid), .wr_idx(commit_rd), .wr_data(commit_value)
    );

    reorder_buffer i_rob (
        .clk, .rst, .cdb(cdb.consumer), .push, .push_rd, .alloc_tag, .full,
        .look_tag_a, .look_tag_b, .look_ready_a, .look_ready_b, .look_value_a, .look_value_b,
        .retire_valid(commit_valid), .retire_rd(commit_rd), .retire_value(commit_value),
        .retire_tag
    );

    // lane 0 alu, lane 1 multiplier
    exec_lane #(.latency(1), .lane(0)) i_alu (
        .clk, .rst, .issue(alu_issue), .op(issue_op), .a(issue_a), .b(issue_b),
        .tag(issue_tag), .busy(alu_busy), .cdb(cdb.producer)
    );

    exec_lane #(.latency(ooo_pkg::mul_latency), .lane(1)) i_mul (
        .clk, .rst, .issue(mul_issue), .op(issue_op), .a(issue_a), .b(issue_b),
        .tag(issue_tag), .busy(mul_busy), .cdb(cdb.producer)
    );

endmodule

`default_nettype wire

/* hw/dispatch_unit.sv */
`default_nettype none

module dispatch_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          inst_req,
    output logic                          inst_ack,
    input  ooo_pkg::alu_op_e              inst_op,
    input  logic [ooo_pkg::reg_idx_w-1:0] inst_rd,
    input  logic [ooo_pkg::reg_idx_w-1:0] inst_rs1,
    input  logic [ooo_pkg::reg_idx_w-1:0] inst_rs2,
    input  logic [15:0]                   inst_imm,
    output logic [ooo_pkg::reg_idx_w-1:0] src_a,
    output logic [ooo_pkg::reg_idx_w-1:0] src_b,
    input  logic                          busy_a,
    input  logic                          busy_b,
    input  logic [ooo_pkg::rob_idx_w-1:0] tag_a,
    input  logic [ooo_pkg::rob_idx_w-1:0] tag_b,
    output logic                          rename,
    output logic [ooo_pkg::reg_idx_w-1:0] rename_rd,
    output logic [ooo_pkg::rob_idx_w-1:0] rename_tag,
    output logic [ooo_pkg::reg_idx_w-1:0] rd_idx_a,
    output logic [ooo_pkg::reg_idx_w-1:0] rd_idx_b,
    input  logic [ooo_pkg::xlen-1:0]      rd_data_a,
    input  logic [ooo_pkg::xlen-1:0]      rd_data_b,
    output logic                          push,
    output logic [ooo_pkg::reg_idx_w-1:0] push_rd,
    input  logic [ooo_pkg::rob_idx_w-1:0] alloc_tag,
    input  logic                          full,
    output logic [ooo_pkg::rob_idx_w-1:0] look_tag_a,
    output logic [ooo_pkg::rob_idx_w-1:0] look_tag_b,
    input  logic                          look_ready_a,
    input  logic                          look_ready_b,
    input  logic [ooo_pkg::xlen-1:0]      look_value_a,
    input  logic [ooo_pkg::xlen-1:0]      look_value_b,
    output logic                          alu_issue,
    output logic                          mul_issue,
    output ooo_pkg::alu_op_e              issue_op,
    output logic [ooo_pkg::xlen-1:0]      issue_a,
    output logic [ooo_pkg::xlen-1:0]      issue_b,
    output logic [ooo_pkg::rob_idx_w-1:0] issue_tag,
    input  logic                          alu_busy,
    input  logic                          mul_busy
);

    ooo_pkg::dispatch_state_e state;
    logic is_li;
    logic is_mul;
    logic ready_a;
    logic ready_b;
    logic lane_busy;
    logic accept;

    assign is_li = (inst_op == ooo_pkg::op_li);
    assign is_mul = (inst_op == ooo_pkg::op_mul);

    // sources go to the rename table, the register file and the rob together
    assign src_a = inst_rs1;
    assign src_b = inst_rs2;
    assign rd_idx_a = inst_rs1;
    assign rd_idx_b = inst_rs2;
    assign look_tag_a = tag_a;
    assign look_tag_b = tag_b;

    // renamed operand must have its result in the rob or on the bus
    assign ready_a = is_li || !busy_a || look_ready_a;
    assign ready_b = is_li || !busy_b || look_ready_b;
    assign lane_busy = is_mul ? mul_busy : alu_busy;

    assign accept = inst_req && (state != ooo_pkg::st_ack) && !full
                    && ready_a && ready_b && !lane_busy;

    assign push = accept;
    assign push_rd = inst_rd;
    assign rename = accept;
    assign rename_rd = inst_rd;
    assign rename_tag = alloc_tag;

    assign alu_issue = accept && !is_mul;
    assign mul_issue = accept && is_mul;
    assign issue_op = inst_op;
    assign issue_tag = alloc_tag;
    assign issue_a = is_li ? ooo_pkg::xlen'(inst_imm) : (busy_a ? look_value_a : rd_data_a);
    assign issue_b = busy_b ? look_value_b : rd_data_b;

    assign inst_ack = (state == ooo_pkg::st_ack);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ooo_pkg::st_idle;
        end else begin
            case (state)
                ooo_pkg::st_idle, ooo_pkg::st_wait_operands: begin
                    if (accept) begin
                        state <= ooo_pkg::st_ack;
                    end else if (inst_req) begin
                        state <= ooo_pkg::st_wait_operands;
                    end
                end
                // hold ack until the requester drops req
                ooo_pkg::st_ack: begin
                    if (!inst_req) begin
                        state <= ooo_pkg::st_idle;
                    end
                end
                default: state <= ooo_pkg::st_idle;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) $rose(inst_ack) |-> $past(inst_req));

endmodule

`default_nettype wire

/* hw/exec_lane.sv */
`default_nettype none

module exec_lane #(
    parameter int latency = 1,
    parameter int lane = 0
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          issue,
    input  ooo_pkg::alu_op_e              op,
    input  logic [ooo_pkg::xlen-1:0]      a,
    input  logic [ooo_pkg::xlen-1:0]      b,
    input  logic [ooo_pkg::rob_idx_w-1:0] tag,
    output logic                          busy,
    cdb_if.producer                       cdb
);

    logic held;
    logic [$clog2(latency+1)-1:0] count;
    logic [ooo_pkg::xlen-1:0] result_q;
    logic [ooo_pkg::rob_idx_w-1:0] tag_q;

    function automatic logic [ooo_pkg::xlen-1:0] compute(
        input ooo_pkg::alu_op_e   f_op,
        input logic [ooo_pkg::xlen-1:0] f_a,
        input logic [ooo_pkg::xlen-1:0] f_b
    );
        case (f_op)
            ooo_pkg::op_li:  return f_a;
            ooo_pkg::op_add: return f_a + f_b;
            ooo_pkg::op_sub: return f_a - f_b;
            ooo_pkg::op_and: return f_a & f_b;
            ooo_pkg::op_xor: return f_a ^ f_b;
            ooo_pkg::op_mul: return f_a * f_b;
            default:         return '0;
        endcase
    endfunction

    // single-cycle lane can take a new op every cycle
    assign busy = (latency > 1) && held;

    assign cdb.valid[lane] = held && (count == 1);
    assign cdb.tag[lane] = tag_q;
    assign cdb.value[lane] = result_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
            count <= '0;
        end else if (issue) begin
            held <= 1'b1;
            count <= latency[$bits(count)-1:0];
        end else if (held) begin
            if (count == 1) begin
                held <= 1'b0;
            end
            count <= count - 1'b1;
        end
    end

    // result is computed up front and just waits out the latency
    always_ff @(posedge clk) begin
        if (issue) begin
            result_q <= compute(op, a, b);
            tag_q <= tag;
        end
    end

    assert property (@(posedge clk) disable iff (rst) issue |-> !busy);

endmodule

`default_nettype wire

/* hw/reorder_buffer.sv */
`default_nettype none

module reorder_buffer (
    input  logic                           clk,
    input  logic                           rst,
    cdb_if.consumer                        cdb,
    input  logic                           push,
    input  logic [ooo_pkg::reg_idx_w-1:0]  push_rd,
    output logic [ooo_pkg::rob_idx_w-1:0]  alloc_tag,
    output logic                           full,
    input  logic [ooo_pkg::rob_idx_w-1:0]  look_tag_a,
    input  logic [ooo_pkg::rob_idx_w-1:0]  look_tag_b,
    output logic                           look_ready_a,
    output logic                           look_ready_b,
    output logic [ooo_pkg::xlen-1:0]       look_value_a,
    output logic [ooo_pkg::xlen-1:0]       look_value_b,
    output logic                           retire_valid,
    output logic [ooo_pkg::reg_idx_w-1:0]  retire_rd,
    output logic [ooo_pkg::xlen-1:0]       retire_value,
    output logic [ooo_pkg::rob_idx_w-1:0]  retire_tag
);

    // head allocates, tail retires
    logic [ooo_pkg::rob_idx_w-1:0] head;
    logic [ooo_pkg::rob_idx_w-1:0] tail;
    logic [ooo_pkg::rob_entries-1:0] occupied;
    logic [ooo_pkg::rob_entries-1:0] ready;
    logic [ooo_pkg::reg_idx_w-1:0] dest_q  [ooo_pkg::rob_entries];
    logic [ooo_pkg::xlen-1:0]      value_q [ooo_pkg::rob_entries];

    assign alloc_tag = head;
    assign full = occupied[head];

    // oldest entry leaves as soon as its result is in
    assign retire_valid = occupied[tail] && ready[tail];
    assign retire_rd = dest_q[tail];
    assign retire_value = value_q[tail];
    assign retire_tag = tail;

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            occupied <= '0;
            ready <= '0;
        end else begin
            if (retire_valid) begin
                occupied[tail] <= 1'b0;
                ready[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end
            for (int i = 0; i < ooo_pkg::cdb_lanes; i++) begin
                if (cdb.valid[i]) begin
                    ready[cdb.tag[i]] <= 1'b1;
                end
            end
            if (push) begin
                occupied[head] <= 1'b1;
                ready[head] <= 1'b0;
                head <= head + 1'b1;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < ooo_pkg::cdb_lanes; i++) begin
            if (cdb.valid[i]) begin
                value_q[cdb.tag[i]] <= cdb.value[i];
            end
        end
        if (push) begin
            dest_q[head] <= push_rd;
        end
    end

    // stored result, or the one on the bus this cycle
    always_comb begin
        look_ready_a = ready[look_tag_a];
        look_value_a = value_q[look_tag_a];
        look_ready_b = ready[look_tag_b];
        look_value_b = value_q[look_tag_b];
        for (int i = 0; i < ooo_pkg::cdb_lanes; i++) begin
            if (cdb.valid[i] && (cdb.tag[i] == look_tag_a)) begin
                look_ready_a = 1'b1;
                look_value_a = cdb.value[i];
            end
            if (cdb.valid[i] && (cdb.tag[i] == look_tag_b)) begin
                look_ready_b = 1'b1;
                look_value_b = cdb.value[i];
            end
        end
    end

    // dispatch must hold off while every slot is taken
    assert property (@(posedge clk) disable iff (rst) push |-> !full);

    // a lane only writes back to an entry still waiting on it
    for (genvar i = 0; i < ooo_pkg::cdb_lanes; i++) begin : g_cdb_chk
        assert property (@(posedge clk) disable iff (rst)
            cdb.valid[i] |-> occupied[cdb.tag[i]] && !ready[cdb.tag[i]]);
    end

endmodule

`default_nettype wire

/* hw/rename_table.sv */
`default_nettype none

module rename_table (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [ooo_pkg::reg_idx_w-1:0] src_a,
    input  logic [ooo_pkg::reg_idx_w-1:0] src_b,
    output logic                          busy_a,
    output logic                          busy_b,
    output logic [ooo_pkg::rob_idx_w-1:0] tag_a,
    output logic [ooo_pkg::rob_idx_w-1:0] tag_b,
    input  logic                          rename,
    input  logic [ooo_pkg::reg_idx_w-1:0] rename_rd,
    input  logic [ooo_pkg::rob_idx_w-1:0] rename_tag,
    input  logic                          retire_valid,
    input  logic [ooo_pkg::reg_idx_w-1:0] retire_rd,
    input  logic [ooo_pkg::rob_idx_w-1:0] retire_tag
);

    logic [ooo_pkg::num_regs-1:0] in_flight;
    logic [ooo_pkg::rob_idx_w-1:0] youngest [ooo_pkg::num_regs];

    assign busy_a = in_flight[src_a];
    assign busy_b = in_flight[src_b];
    assign tag_a = youngest[src_a];
    assign tag_b = youngest[src_b];

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= '0;
        end else begin
            // only the youngest producer frees the mapping
            if (retire_valid && (youngest[retire_rd] == retire_tag)) begin
                in_flight[retire_rd] <= 1'b0;
            end
            // a new rename of the same register takes priority
            if (rename) begin
                in_flight[rename_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rename) begin
            youngest[rename_rd] <= rename_tag;
        end
    end

endmodule

`default_nettype wire

/* hw/arch_regfile.sv */
`default_nettype none

module arch_regfile (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [ooo_pkg::reg_idx_w-1:0] rd_idx_a,
    input  logic [ooo_pkg::reg_idx_w-1:0] rd_idx_b,
    output logic [ooo_pkg::xlen-1:0]      rd_data_a,
    output logic [ooo_pkg::xlen-1:0]      rd_data_b,
    input  logic                          wr_en,
    input  logic [ooo_pkg::reg_idx_w-1:0] wr_idx,
    input  logic [ooo_pkg::xlen-1:0]      wr_data
);

    logic [ooo_pkg::xlen-1:0] regs [ooo_pkg::num_regs];

    // no write bypass, the rename table covers the retire cycle
    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ooo_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* hw/cdb_if.sv */
`default_nettype none

interface cdb_if;

    // one strobe, tag and result per lane
    logic                          valid [ooo_pkg::cdb_lanes];
    logic [ooo_pkg::rob_idx_w-1:0] tag   [ooo_pkg::cdb_lanes];
    logic [ooo_pkg::xlen-1:0]      value [ooo_pkg::cdb_lanes];

    modport producer (
        output valid,
        output tag,
        output value
    );

    modport consumer (
        input valid,
        input tag,
        input value
    );

endinterface

`default_nettype wire

/* hw/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

    // datapath and architectural state
    localparam int xlen = 32;
    localparam int reg_idx_w = 5;
    localparam int num_regs = 32;

    // reorder buffer, one tag per entry
    localparam int rob_idx_w = 4;
    localparam int rob_entries = 16;

    // lane 0 is the alu, lane 1 the multiplier
    localparam int cdb_lanes = 2;
    localparam int mul_latency = 4;

    // op_li takes its value from the zero-extended 16-bit immediate
    typedef enum logic [2:0] {
        op_li,
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_mul
    } alu_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_operands,
        st_ack
    } dispatch_state_e;

endpackage

`default_nettype wire
